/* Makefile */
# Verilator build for the cache refill subsystem

VERILATOR ?= verilator
TOP       ?= tb_cache_refill
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
+incdir+include
source/cache_biu_pkg.sv
source/biu_bus_if.sv
source/cache_biu_ctrl.sv
source/biu_arbiter.sv
source/cache_refill_top.sv
sim/tb_cache_refill.sv

/* include/cache_biu_config.svh */
`ifndef CACHE_BIU_CONFIG_SVH
`define CACHE_BIU_CONFIG_SVH

//////////////////////////////
// bus geometry
//////////////////////////////

`define CB_ADDR_W          32                  // byte address
`define CB_DATA_W          32                  // one bus word

//////////////////////////////
// cache line
//////////////////////////////

// words per line, also the wrap burst length
`define CB_LINE_WORDS      4

//////////////////////////////
// outstanding transfers
//////////////////////////////

`define CB_INFLIGHT_DEPTH  2                   // strobes open on the bus
`define CB_QUEUE_DEPTH     `CB_INFLIGHT_DEPTH  // arbiter owner queue

`endif

/* sim/tb_cache_refill.sv */
`timescale 1ns/1ns
`include "cache_biu_config.svh"

module tb_cache_refill;

  localparam int          NUM_ROWS  = 9;
  localparam int          MAX_CYC   = 200 * NUM_ROWS + 20;   // rows plus reset
  localparam logic [31:0] MAGIC     = 32'hA5A5_0000;         // memory data = addr ^ MAGIC
  localparam int          RESP_LAT  = 3;                     // cycles before first beat
  localparam int          K_REFILL  = 0;
  localparam int          K_NC      = 1;
  localparam int          K_BOTH    = 2;                     // refill on both clients
  localparam int          K_FLUSH   = 3;                     // flush over a single read

  logic clk_i;
  logic rst_ni;

  // per client, index 0 is ic and 1 is dc
  logic                          flush [2];
  cache_biu_pkg::biucmd_e        biucmd [2];
  logic                          nc_req [2];
  logic                          req [2];
  cache_biu_pkg::addr_t          adr [2];
  logic                          cmd_ack [2];
  logic                          nc_ack [2];
  cache_biu_pkg::word_t          nc_q [2];
  logic                          in_buf [2];
  cache_biu_pkg::line_t          biubuf [2];
  cache_biu_pkg::line_t          cmem [2];
  cache_biu_pkg::cnt_t           infl [2];

  // external bus
  logic                          biu_stb_o;
  logic                          biu_stb_ack_i;
  cache_biu_pkg::addr_t          biu_adri_o;
  cache_biu_pkg::biu_type_e      biu_type_o;
  cache_biu_pkg::addr_t          biu_adro_i;
  cache_biu_pkg::word_t          biu_q_i;
  logic                          biu_ack_i;
  logic                          biu_err_i;

  // stimulus table
  int                            row_kind [NUM_ROWS];
  int                            row_client [NUM_ROWS];
  logic [31:0]                   row_adr [NUM_ROWS];
  logic [31:0]                   row_adr2 [NUM_ROWS];        // dc address of both rows
  logic                          row_err [NUM_ROWS];         // expect err instead of data

  int                            errors = 0;
  int                            cycles = 0;
  integer                        seed = 5288;
  int                            cur_client = 0;
  logic                          both_row = 1'b0;
  logic                          last_owner = 1'b1;          // rr starts favouring ic
  cache_biu_pkg::biu_type_e      last_type;

  // responder state
  logic [31:0]                   rq_adr [$];
  cache_biu_pkg::biu_type_e      rq_type [$];
  int                            acc_delay = 0;
  int                            resp_wait = RESP_LAT;
  int                            beat = 0;
  logic [1:0]                    widx;
  logic [31:0]                   badr;
  logic                          last_beat;
  logic                          owner;

  cache_refill_top u_cache_refill_top (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .ic_flush_i (flush[0]), .ic_biucmd_i (biucmd[0]), .ic_biucmd_ack_o (cmd_ack[0]),
    .ic_noncacheable_req_i (nc_req[0]), .ic_noncacheable_ack_o (nc_ack[0]),
    .ic_noncacheable_q_o (nc_q[0]), .ic_req_i (req[0]), .ic_adr_i (adr[0]),
    .ic_in_biubuffer_o (in_buf[0]), .ic_biubuffer_o (biubuf[0]),
    .ic_cachemem_dat_o (cmem[0]), .ic_inflight_cnt_o (infl[0]),
    .dc_flush_i (flush[1]), .dc_biucmd_i (biucmd[1]), .dc_biucmd_ack_o (cmd_ack[1]),
    .dc_noncacheable_req_i (nc_req[1]), .dc_noncacheable_ack_o (nc_ack[1]),
    .dc_noncacheable_q_o (nc_q[1]), .dc_req_i (req[1]), .dc_adr_i (adr[1]),
    .dc_in_biubuffer_o (in_buf[1]), .dc_biubuffer_o (biubuf[1]),
    .dc_cachemem_dat_o (cmem[1]), .dc_inflight_cnt_o (infl[1]),
    .biu_stb_o (biu_stb_o), .biu_stb_ack_i (biu_stb_ack_i), .biu_adri_o (biu_adri_o),
    .biu_type_o (biu_type_o), .biu_adro_i (biu_adro_i), .biu_q_i (biu_q_i),
    .biu_ack_i (biu_ack_i), .biu_err_i (biu_err_i)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;                               // 8 ns period
  end

  // watchdog
  always @(posedge clk_i)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYC)
    begin
      $display("timeout after %0d cycles, a transfer never completed", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic [127:0] exp, input logic [127:0] act);
    assert (exp === act)
    else
    begin
      $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  //////////////////////////////
  // memory responder
  //////////////////////////////

  always @(posedge clk_i)
  begin
    biu_ack_i <= 1'b0;
    biu_err_i <= 1'b0;
    if (rst_ni)
    begin
      if (biu_stb_ack_i && biu_stb_o)                         // strobe taken last cycle
      begin
        rq_adr.push_back(biu_adri_o);
        rq_type.push_back(biu_type_o);
        last_type     <= biu_type_o;
        biu_stb_ack_i <= 1'b0;
        acc_delay     = $unsigned($random(seed)) % 3;
        owner = both_row ? (biu_adri_o[31:4] == adr[1][31:4]) : cur_client[0];
        if (both_row)
          assert (owner != last_owner)
          else
          begin
            $display("round robin order broken, client %0d won twice in a row", owner);
            errors++;
          end
        last_owner = owner;
      end
      else if (biu_stb_o && !biu_stb_ack_i)
      begin
        if (acc_delay == 0) biu_stb_ack_i <= 1'b1;
        else acc_delay--;
      end

      if (rq_adr.size() != 0)
      begin
        if (resp_wait != 0)
          resp_wait--;
        else
        begin
          widx = rq_adr[0][3:2] + beat[1:0];                // wrap inside the line
          badr = {rq_adr[0][31:4], widx, 2'b00};
          biu_adro_i <= badr;
          biu_q_i    <= badr ^ MAGIC;
          if (badr[31])
          begin
            biu_err_i <= 1'b1;
            last_beat = 1'b1;
          end
          else
          begin
            biu_ack_i <= 1'b1;
            last_beat = (rq_type[0] == cache_biu_pkg::SINGLE) || (beat == 3);
          end
          if (last_beat)
          begin
            void'(rq_adr.pop_front());
            void'(rq_type.pop_front());
            beat      = 0;
            resp_wait = RESP_LAT;
          end
          else
            beat++;
        end
      end
    end
  end

  //////////////////////////////
  // row tasks
  //////////////////////////////

  task automatic check_line(input string name, input cache_biu_pkg::line_t dat,
                            input logic [31:0] base);
    for (int w = 0; w < `CB_LINE_WORDS; w++)
      check_val(name, (base + 4 * w) ^ MAGIC, dat[w*32 +: 32]);
  endtask

  task automatic check_hit(input int c, input logic [31:0] base);
    @(posedge clk_i);
    req[c] <= 1'b1;
    adr[c] <= base + 32'h8;                                  // same line
    @(negedge clk_i);
    check_val("in_biubuffer", 1'b1, in_buf[c]);
    check_line("biubuffer word", biubuf[c], base);
    @(posedge clk_i);
    adr[c] <= base + 32'h100;                                // other line
    @(negedge clk_i);
    check_val("in_biubuffer", 1'b0, in_buf[c]);
    @(posedge clk_i);
    req[c] <= 1'b0;
  endtask

  // refill on one or both clients, each waits for its biucmd_ack
  task automatic run_refill(input logic on0, input logic on1, input logic [31:0] b0,
                            input logic [31:0] b1, input logic exp_err);
    logic done [2];
    logic [31:0] base [2];
    done[0] = !on0;
    done[1] = !on1;
    base[0] = {b0[31:4], 4'h0};
    base[1] = {b1[31:4], 4'h0};
    @(posedge clk_i);
    if (on0)
    begin
      biucmd[0] <= cache_biu_pkg::READWAY;
      adr[0]    <= b0;
    end
    if (on1)
    begin
      biucmd[1] <= cache_biu_pkg::READWAY;
      adr[1]    <= b1;
    end
    while (!(done[0] && done[1]))
    begin
      @(negedge clk_i);
      for (int c = 0; c < 2; c++)
        if (!done[c] && cmd_ack[c])
        begin
          done[c] = 1'b1;
          if (exp_err) check_val("biu_err_i", 1'b1, biu_err_i);
          else check_line("cachemem_dat word", cmem[c], base[c]);
        end
      @(posedge clk_i);
      for (int c = 0; c < 2; c++)
        if (done[c]) biucmd[c] <= cache_biu_pkg::NOP;
    end
    if (!exp_err)
    begin
      if (on0) check_hit(0, base[0]);
      if (on1) check_hit(1, base[1]);
    end
  endtask

  task automatic run_nc(input int c, input logic [31:0] a);
    @(posedge clk_i);
    nc_req[c] <= 1'b1;
    adr[c]    <= a;
    do @(negedge clk_i); while (!nc_ack[c]);
    check_val("noncacheable_q", a ^ MAGIC, nc_q[c]);
    check_val("biu_type_o", cache_biu_pkg::SINGLE, last_type);
    @(posedge clk_i);
    nc_req[c] <= 1'b0;
  endtask

  task automatic run_flush(input int c, input logic [31:0] a);
    @(posedge clk_i);
    nc_req[c] <= 1'b1;
    adr[c]    <= a;
    do @(negedge clk_i); while (infl[c] == '0);             // read is on the bus
    @(posedge clk_i);
    flush[c]  <= 1'b1;
    nc_req[c] <= 1'b0;
    @(posedge clk_i);
    flush[c]  <= 1'b0;
    repeat (12)                                              // window covers the response
    begin
      @(negedge clk_i);
      check_val("noncacheable_ack", 1'b0, nc_ack[c]);
    end
    check_val("inflight_cnt", '0, infl[c]);
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial
  begin
    rst_ni        = 1'b0;
    biu_stb_ack_i = 1'b0;
    biu_adro_i    = '0;
    biu_q_i       = '0;
    biu_ack_i     = 1'b0;
    biu_err_i     = 1'b0;
    for (int c = 0; c < 2; c++)
    begin
      flush[c]  = 1'b0;
      biucmd[c] = cache_biu_pkg::NOP;
      nc_req[c] = 1'b0;
      req[c]    = 1'b0;
      adr[c]    = '0;
    end
    // kind, client, address, second address, err expected
    // both rows follow an ic win and a dc win, so each must start with the other client
    row_kind = '{K_REFILL, K_REFILL, K_NC, K_NC, K_BOTH, K_FLUSH, K_BOTH, K_REFILL,
                 K_REFILL};
    row_client = '{0, 1, 1, 0, 0, 1, 0, 0, 0};
    row_adr  = '{32'h0000_1000, 32'h0000_2044, 32'h0000_300C, 32'h0000_3008,
                 32'h0000_4010, 32'h0000_6004, 32'h0000_4C00, 32'h8000_0040,
                 32'h0000_7030};
    row_adr2 = '{32'h0, 32'h0, 32'h0, 32'h0, 32'h0000_5020, 32'h0, 32'h0000_5C3C, 32'h0,
                 32'h0};
    row_err  = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};

    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    check_val("biu_stb_o", 1'b0, biu_stb_o);
    check_val("ic inflight_cnt", '0, infl[0]);

    for (int r = 0; r < NUM_ROWS; r++)
    begin
      cur_client = row_client[r];
      both_row   = (row_kind[r] == K_BOTH);
      case (row_kind[r])
        K_REFILL: run_refill(cur_client == 0, cur_client == 1, row_adr[r], row_adr[r],
                             row_err[r]);
        K_NC:     run_nc(cur_client, row_adr[r]);
        K_BOTH:   run_refill(1'b1, 1'b1, row_adr[r], row_adr2[r], 1'b0);
        default:  run_flush(cur_client, row_adr[r]);
      endcase
      both_row = 1'b0;
      repeat (2) @(posedge clk_i);
    end

    $display("errors: %0d", errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

/* source/biu_arbiter.sv */
`timescale 1ns/1ns
`include "cache_biu_config.svh"

module biu_arbiter (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  biu_bus_if.arbiter                ic_bus,             // client 0
  biu_bus_if.arbiter                dc_bus,             // client 1

  output logic                      biu_stb_o,
  input  logic                      biu_stb_ack_i,
  output cache_biu_pkg::addr_t      biu_adri_o,
  output cache_biu_pkg::biu_type_e  biu_type_o,
  input  cache_biu_pkg::addr_t      biu_adro_i,
  input  cache_biu_pkg::word_t      biu_q_i,
  input  logic                      biu_ack_i,
  input  logic                      biu_err_i
);

  localparam int DEPTH = `CB_QUEUE_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [1:0]                 req;
  logic                       sel;                      // client on the bus now
  logic                       rr_ptr;                   // favoured client
  logic                       grant_vld;
  logic                       grant_id;
  logic                       fire, pop, head, head_vld;
  logic                       to_ic, to_dc;
  logic                       q_full, q_empty;
  logic [DEPTH-1:0]           q_owner;
  cache_biu_pkg::word_idx_t   q_beats [DEPTH];          // beats left minus one
  logic [PTR_W-1:0]           rd_ptr, wr_ptr;
  cache_biu_pkg::cnt_t        q_cnt;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    ptr_next = (ptr == PTR_W'(DEPTH-1)) ? '0 : ptr + 1'b1;
  endfunction

  //////////////////////////////
  // request select
  //////////////////////////////

  assign req = {dc_bus.stb, ic_bus.stb};

  always_comb
  begin
    if (grant_vld)         sel = grant_id;              // held until stb_ack
    else if (req[rr_ptr])  sel = rr_ptr;
    else                   sel = ~rr_ptr;
  end

  assign biu_stb_o  = req[sel] & ~q_full;               // no strobe with the queue full
  assign biu_adri_o = sel ? dc_bus.adr   : ic_bus.adr;
  assign biu_type_o = sel ? dc_bus.btype : ic_bus.btype;
  assign fire       = biu_stb_o & biu_stb_ack_i;

  assign ic_bus.stb_ack = fire & ~sel;
  assign dc_bus.stb_ack = fire &  sel;

  //////////////////////////////
  // response steering
  //////////////////////////////

  assign head     = q_owner[rd_ptr];
  assign head_vld = ~q_empty;
  assign to_ic    = head_vld & ~head;
  assign to_dc    = head_vld &  head;
  assign pop      = head_vld & (biu_err_i | (biu_ack_i & (q_beats[rd_ptr] == '0)));

  assign ic_bus.ack  = biu_ack_i & to_ic;
  assign ic_bus.err  = biu_err_i & to_ic;
  assign ic_bus.q    = to_ic ? biu_q_i    : '0;
  assign ic_bus.adro = to_ic ? biu_adro_i : '0;
  assign dc_bus.ack  = biu_ack_i & to_dc;
  assign dc_bus.err  = biu_err_i & to_dc;
  assign dc_bus.q    = to_dc ? biu_q_i    : '0;
  assign dc_bus.adro = to_dc ? biu_adro_i : '0;

  //////////////////////////////
  // grant and owner queue
  //////////////////////////////

  assign q_full  = (q_cnt == cache_biu_pkg::cnt_t'(DEPTH));
  assign q_empty = (q_cnt == '0);

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      rr_ptr    <= 1'b0;
      grant_vld <= 1'b0;
      grant_id  <= 1'b0;
      rd_ptr    <= '0;
      wr_ptr    <= '0;
      q_cnt     <= '0;
    end
    else
    begin
      grant_vld <= req[sel] & ~fire;                    // released on stb_ack
      grant_id  <= sel;
      if (fire) rr_ptr <= ~sel;                         // other client goes first next
      if (fire) wr_ptr <= ptr_next(wr_ptr);
      if (pop)  rd_ptr <= ptr_next(rd_ptr);
      unique case ({fire, pop})
        2'b10:   q_cnt <= q_cnt + 1'b1;
        2'b01:   q_cnt <= q_cnt - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (fire)
    begin
      q_owner[wr_ptr] <= sel;
      q_beats[wr_ptr] <= (biu_type_o == cache_biu_pkg::WRAP4) ?
                         cache_biu_pkg::word_idx_t'(`CB_LINE_WORDS-1) : '0;
    end
    if (head_vld && biu_ack_i && !pop)
      q_beats[rd_ptr] <= q_beats[rd_ptr] - 1'b1;        // mid burst beat
  end

endmodule

/* source/biu_bus_if.sv */
`timescale 1ns/1ns

// one cache controller to arbiter link
interface biu_bus_if;

  // request side
  logic                      stb;               // access request
  cache_biu_pkg::addr_t      adr;               // start address
  cache_biu_pkg::biu_type_e  btype;             // burst type

  // response side
  logic                      stb_ack;           // strobe taken
  logic                      ack;               // beat done
  logic                      err;               // beat failed, ends the transfer
  cache_biu_pkg::word_t      q;                 // read data
  cache_biu_pkg::addr_t      adro;              // address of this beat

  modport client (
    output stb,
    output adr,
    output btype,
    input  stb_ack,
    input  ack,
    input  err,
    input  q,
    input  adro
  );

  modport arbiter (
    input  stb, adr, btype,
    output stb_ack, ack, err, q, adro
  );

endinterface

/* source/cache_biu_ctrl.sv */
`timescale 1ns/1ns
`include "cache_biu_config.svh"

module cache_biu_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  input  logic                    flush_i,              // pipe flush
  input  cache_biu_pkg::biucmd_e  biucmd_i,
  output logic                    biucmd_ack_o,         // refill done
  input  logic                    noncacheable_req_i,
  output logic                    noncacheable_ack_o,

  input  logic                    req_i,                // cache lookup
  input  cache_biu_pkg::addr_t    adr_i,
  output logic                    in_biubuffer_o,       // lookup hits the line buffer
  output cache_biu_pkg::line_t    biubuffer_o,
  output cache_biu_pkg::line_t    cachemem_dat_o,       // line for the DAT memory
  output cache_biu_pkg::cnt_t     inflight_cnt_o,

  biu_bus_if.client               bus
);

  //////////////////////////////
  // constants
  //////////////////////////////

  localparam int IDX_W     = $bits(cache_biu_pkg::word_idx_t);
  localparam int BYTE_BITS = $clog2(`CB_DATA_W/8);      // byte offset in a word
  localparam int LINE_LSB  = BYTE_BITS + IDX_W;         // first line address bit

  cache_biu_pkg::biufsm_e     state;
  cache_biu_pkg::word_idx_t   burst_cnt;                // beats left minus one
  cache_biu_pkg::addr_t       adr_hold;                 // last issued strobe address
  cache_biu_pkg::cnt_t        discard;                  // stale responses to drop
  logic [`CB_LINE_WORDS-1:0]  buf_valid;                // per word in biubuffer
  logic                       nc_pend;                  // single read on the bus
  logic                       issue_ok;
  logic                       resp;
  logic                       xfer_end;
  logic                       nc_fire;
  cache_biu_pkg::word_idx_t   beat_idx;
  cache_biu_pkg::word_idx_t   req_idx;

  //////////////////////////////
  // response decode
  //////////////////////////////

  assign beat_idx = bus.adro[BYTE_BITS +: IDX_W];       // slot of returning beat
  assign req_idx  = adr_i[BYTE_BITS +: IDX_W];
  assign resp     = bus.ack | bus.err;

  // last response of a transfer, a single or the closing beat of a burst
  assign xfer_end = bus.err |
                    (bus.ack & ((state != cache_biu_pkg::BURST) | (burst_cnt == '0)));

  // one transfer at a time, none while stale responses are pending
  assign issue_ok = ~nc_pend & (discard == '0) & ~flush_i;
  assign nc_fire  = (state == cache_biu_pkg::IDLE) & (biucmd_i == cache_biu_pkg::NOP) &
                    bus.stb & bus.stb_ack;

  //////////////////////////////
  // request side
  //////////////////////////////

  always_comb
  begin
    bus.stb   = 1'b0;
    bus.adr   = adr_hold;                               // wait4biu replays this
    bus.btype = cache_biu_pkg::WRAP4;
    unique case (state)
      cache_biu_pkg::IDLE:
      begin
        if (biucmd_i == cache_biu_pkg::READWAY)
        begin
          bus.stb = issue_ok;
          bus.adr = {adr_i[`CB_ADDR_W-1:LINE_LSB], {LINE_LSB{1'b0}}};  // line aligned
        end
        else
        begin
          bus.stb   = noncacheable_req_i & issue_ok;
          bus.adr   = adr_i;
          bus.btype = cache_biu_pkg::SINGLE;
        end
      end
      cache_biu_pkg::WAIT4BIU: bus.stb = 1'b1;          // stretch until stb_ack
      default: ;                                        // burst running, strobe low
    endcase
  end

  //////////////////////////////
  // refill fsm
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      state <= cache_biu_pkg::IDLE;
    else
      unique case (state)
        cache_biu_pkg::IDLE:
          if (biucmd_i == cache_biu_pkg::READWAY && issue_ok)
            state <= bus.stb_ack ? cache_biu_pkg::BURST : cache_biu_pkg::WAIT4BIU;
        cache_biu_pkg::WAIT4BIU:
          if (bus.stb_ack) state <= cache_biu_pkg::BURST;
        cache_biu_pkg::BURST:
          if (biucmd_ack_o) state <= cache_biu_pkg::IDLE;
        default: state <= cache_biu_pkg::IDLE;
      endcase
  end

  assign biucmd_ack_o = (state == cache_biu_pkg::BURST) &
                        ((bus.ack & (burst_cnt == '0)) | bus.err);

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      burst_cnt <= '0;
      nc_pend   <= 1'b0;
      buf_valid <= '0;
    end
    else
    begin
      if (state != cache_biu_pkg::BURST)
        burst_cnt <= cache_biu_pkg::word_idx_t'(`CB_LINE_WORDS-1);
      else if (bus.ack)
        burst_cnt <= burst_cnt - 1'b1;

      if (nc_fire)
        nc_pend <= 1'b1;
      else if (flush_i || resp)
        nc_pend <= 1'b0;                                // answered or abandoned

      if (state == cache_biu_pkg::IDLE && bus.stb)
        buf_valid <= '0;                                // new transfer, old line gone
      else if (state == cache_biu_pkg::BURST && bus.ack)
        buf_valid[beat_idx] <= 1'b1;
    end
  end

  //////////////////////////////
  // line buffer
  //////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (state == cache_biu_pkg::IDLE && bus.stb)
      adr_hold <= bus.adr;
    if (state == cache_biu_pkg::BURST && bus.ack)
      biubuffer_o[beat_idx*`CB_DATA_W +: `CB_DATA_W] <= bus.q;
  end

  // buffer plus the beat arriving now, so the last beat needs no extra cycle
  always_comb
  begin
    cachemem_dat_o = biubuffer_o;
    cachemem_dat_o[beat_idx*`CB_DATA_W +: `CB_DATA_W] = bus.q;
  end

  assign in_biubuffer_o = req_i &
                          (adr_hold[`CB_ADDR_W-1:LINE_LSB] == adr_i[`CB_ADDR_W-1:LINE_LSB]) &
                          buf_valid[req_idx];

  //////////////////////////////
  // in-flight and flush
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      inflight_cnt_o <= '0;
    else
      unique case ({bus.stb & bus.stb_ack, xfer_end})
        2'b10:   inflight_cnt_o <= inflight_cnt_o + 1'b1;
        2'b01:   inflight_cnt_o <= inflight_cnt_o - 1'b1;
        default: ;                                      // none or both
      endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      discard <= '0;
    else if (flush_i)
    begin
      if (xfer_end && inflight_cnt_o != '0)
        discard <= inflight_cnt_o - 1'b1;               // one lands right now
      else
        discard <= inflight_cnt_o;
    end
    else if (discard != '0 && resp)
      discard <= discard - 1'b1;
  end

  assign noncacheable_ack_o = bus.ack & nc_pend & ~flush_i & (discard == '0);

endmodule

/* source/cache_biu_pkg.sv */
`include "cache_biu_config.svh"

package cache_biu_pkg;

  //////////////////////////////
  // vectors
  //////////////////////////////

  typedef logic [`CB_ADDR_W-1:0]                  addr_t;     // byte address
  typedef logic [`CB_DATA_W-1:0]                  word_t;     // bus word
  typedef logic [`CB_LINE_WORDS*`CB_DATA_W-1:0]   line_t;     // whole line, word 0 at lsb
  typedef logic [$clog2(`CB_LINE_WORDS)-1:0]      word_idx_t; // word in line

  // counts 0 .. inflight depth inclusive
  typedef logic [$clog2(`CB_INFLIGHT_DEPTH+1)-1:0] cnt_t;

  //////////////////////////////
  // encodings
  //////////////////////////////

  typedef enum logic {
    NOP,                                        // idle, single reads allowed
    READWAY                                     // line refill
  } biucmd_e;

  typedef enum logic {
    SINGLE,
    WRAP4                                       // 4 beats, wraps at line end
  } biu_type_e;

  typedef enum logic [1:0] {
    IDLE,
    WAIT4BIU,                                   // strobe held, no stb_ack yet
    BURST                                       // collecting beats
  } biufsm_e;

endpackage

/* source/cache_refill_top.sv */
`timescale 1ns/1ns

module cache_refill_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // instruction cache side
  input  logic                      ic_flush_i,
  input  cache_biu_pkg::biucmd_e    ic_biucmd_i,
  output logic                      ic_biucmd_ack_o,
  input  logic                      ic_noncacheable_req_i,
  output logic                      ic_noncacheable_ack_o,
  output cache_biu_pkg::word_t      ic_noncacheable_q_o,
  input  logic                      ic_req_i,
  input  cache_biu_pkg::addr_t      ic_adr_i,
  output logic                      ic_in_biubuffer_o,
  output cache_biu_pkg::line_t      ic_biubuffer_o,
  output cache_biu_pkg::line_t      ic_cachemem_dat_o,
  output cache_biu_pkg::cnt_t       ic_inflight_cnt_o,

  // data cache side
  input  logic                      dc_flush_i,
  input  cache_biu_pkg::biucmd_e    dc_biucmd_i,
  output logic                      dc_biucmd_ack_o,
  input  logic                      dc_noncacheable_req_i,
  output logic                      dc_noncacheable_ack_o,
  output cache_biu_pkg::word_t      dc_noncacheable_q_o,
  input  logic                      dc_req_i,
  input  cache_biu_pkg::addr_t      dc_adr_i,
  output logic                      dc_in_biubuffer_o,
  output cache_biu_pkg::line_t      dc_biubuffer_o,
  output cache_biu_pkg::line_t      dc_cachemem_dat_o,
  output cache_biu_pkg::cnt_t       dc_inflight_cnt_o,

  // external bus
  output logic                      biu_stb_o,
  input  logic                      biu_stb_ack_i,
  output cache_biu_pkg::addr_t      biu_adri_o,
  output cache_biu_pkg::biu_type_e  biu_type_o,
  input  cache_biu_pkg::addr_t      biu_adro_i,
  input  cache_biu_pkg::word_t      biu_q_i,
  input  logic                      biu_ack_i,
  input  logic                      biu_err_i
);

  biu_bus_if ic_bus ();
  biu_bus_if dc_bus ();

  assign ic_noncacheable_q_o = ic_bus.q;                // steered word, valid with ack
  assign dc_noncacheable_q_o = dc_bus.q;

  cache_biu_ctrl u_ic_ctrl (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .flush_i            (ic_flush_i),
    .biucmd_i           (ic_biucmd_i),
    .biucmd_ack_o       (ic_biucmd_ack_o),
    .noncacheable_req_i (ic_noncacheable_req_i),
    .noncacheable_ack_o (ic_noncacheable_ack_o),
    .req_i              (ic_req_i),
    .adr_i              (ic_adr_i),
    .in_biubuffer_o     (ic_in_biubuffer_o),
    .biubuffer_o        (ic_biubuffer_o),
    .cachemem_dat_o     (ic_cachemem_dat_o),
    .inflight_cnt_o     (ic_inflight_cnt_o),
    .bus                (ic_bus.client)
  );

  cache_biu_ctrl u_dc_ctrl (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .flush_i            (dc_flush_i),
    .biucmd_i           (dc_biucmd_i),
    .biucmd_ack_o       (dc_biucmd_ack_o),
    .noncacheable_req_i (dc_noncacheable_req_i),
    .noncacheable_ack_o (dc_noncacheable_ack_o),
    .req_i              (dc_req_i),
    .adr_i              (dc_adr_i),
    .in_biubuffer_o     (dc_in_biubuffer_o),
    .biubuffer_o        (dc_biubuffer_o),
    .cachemem_dat_o     (dc_cachemem_dat_o),
    .inflight_cnt_o     (dc_inflight_cnt_o),
    .bus                (dc_bus.client)
  );

  // ic is client 0, dc is client 1
  biu_arbiter u_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ic_bus        (ic_bus.arbiter),
    .dc_bus        (dc_bus.arbiter),
    .biu_stb_o     (biu_stb_o),
    .biu_stb_ack_i (biu_stb_ack_i),
    .biu_adri_o    (biu_adri_o),
    .biu_type_o    (biu_type_o),
    .biu_adro_i    (biu_adro_i),
    .biu_q_i       (biu_q_i),
    .biu_ack_i     (biu_ack_i),
    .biu_err_i     (biu_err_i)
  );

endmodule
